//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lsu_pipe
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- lsu_agen.sv
// EX1 address generation
// Adds base and offset, checks natural alignment for the access size,
// builds the expected byte-lane mask and issues the L1D chunk read

`default_nettype none

module lsu_agen (
  input  wire logic               i_valid,
  input  wire lsu_pkg::xlen_t     i_base,
  input  wire lsu_pkg::xlen_t     i_offset,
  input  wire lsu_pkg::size_e     i_size,

  output lsu_pkg::xlen_t          o_vaddr,
  output logic                    o_misaligned,
  output lsu_pkg::lane_mask_t     o_lane_mask,

  output logic                    o_l1d_rd_valid,
  output lsu_pkg::xlen_t          o_l1d_rd_addr
);

  // No translation, so this also serves as the physical address
  assign o_vaddr = i_base + i_offset;

  // --------------------------------------------------------------------------
  // Alignment and lane mask
  // --------------------------------------------------------------------------
  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: begin
        o_misaligned = 1'b0;
        o_lane_mask  = 8'h01;
      end
      lsu_pkg::SIZE_H: begin
        o_misaligned = o_vaddr[0];
        o_lane_mask  = 8'h03;
      end
      lsu_pkg::SIZE_W: begin
        o_misaligned = |o_vaddr[1:0];
        o_lane_mask  = 8'h0f;
      end
      default: begin
        // Doubleword
        o_misaligned = |o_vaddr[2:0];
        o_lane_mask  = 8'hff;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // L1D read request
  // --------------------------------------------------------------------------
  // A misaligned load goes straight to the exception path
  assign o_l1d_rd_valid = i_valid & ~o_misaligned;

  // Chunk aligned, the offset inside the chunk is applied in EX2
  assign o_l1d_rd_addr = {o_vaddr[lsu_pkg::XLEN-1:lsu_pkg::LINE_OFS_W],
                          {lsu_pkg::LINE_OFS_W{1'b0}}};

endmodule

`default_nettype wire

//--- lsu_load_align.sv
// EX2 load data alignment
// Selects the doubleword out of the L1D chunk, merges store-forwarded
// bytes over it, decides replay on a miss that forwarding did not cover,
// and extends the result to XLEN by size and sign

`default_nettype none

module lsu_load_align (
  input  wire logic                                  i_valid,
  input  wire logic                                  i_misaligned,
  input  wire lsu_pkg::xlen_t                        i_vaddr,
  input  wire lsu_pkg::size_e                        i_size,
  input  wire logic                                  i_sign,
  input  wire lsu_pkg::lane_mask_t                   i_lane_mask,

  input  wire logic [lsu_pkg::LINE_BYTES*8-1:0]      i_l1d_rd_data,
  input  wire logic                                  i_l1d_rd_miss,

  input  wire lsu_pkg::lane_mask_t                   i_fwd_mask,
  input  wire lsu_pkg::xlen_t                        i_fwd_data,

  output logic                                       o_fwd_check_valid,
  output lsu_pkg::lane_mask_t                        o_fwd_check_mask,
  output lsu_pkg::xlen_t                             o_load_data,
  output logic                                       o_replay
);

  logic [lsu_pkg::LINE_OFS_W-1:0]   w_line_ofs;
  logic [lsu_pkg::DW_OFS_W-1:0]     w_dw_ofs;
  logic [lsu_pkg::LINE_BYTES*8-1:0] w_line_shifted;
  lsu_pkg::xlen_t                   w_cache_data;
  lsu_pkg::lane_mask_t              w_fwd_mask;
  lsu_pkg::xlen_t                   w_fwd_data;
  lsu_pkg::xlen_t                   w_merged;
  logic                             w_fwd_full;
  logic                             w_load_ok;
  logic                             w_top_bit;
  logic                             w_fill;

  assign w_line_ofs = i_vaddr[lsu_pkg::LINE_OFS_W-1:0];
  assign w_dw_ofs   = i_vaddr[lsu_pkg::DW_OFS_W-1:0];
  assign w_load_ok  = i_valid & ~i_misaligned;

  // --------------------------------------------------------------------------
  // Forward check request
  // --------------------------------------------------------------------------
  // Mask is in doubleword lanes, as the store side sees memory
  assign o_fwd_check_valid = w_load_ok;
  assign o_fwd_check_mask  = i_lane_mask << w_dw_ofs;

  // --------------------------------------------------------------------------
  // Byte-lane alignment and merge
  // --------------------------------------------------------------------------
  // Bring the first loaded byte down to lane 0 for both sources
  assign w_line_shifted = i_l1d_rd_data >> {w_line_ofs, 3'b000};
  assign w_cache_data   = w_line_shifted[lsu_pkg::XLEN-1:0];
  assign w_fwd_mask     = i_fwd_mask >> w_dw_ofs;
  assign w_fwd_data     = i_fwd_data >> {w_dw_ofs, 3'b000};

  // Store data is younger than the cache copy
  always_comb begin
    for (int b = 0; b < lsu_pkg::DW_BYTES; b++) begin
      w_merged[b*8 +: 8] = w_fwd_mask[b] ? w_fwd_data[b*8 +: 8] : w_cache_data[b*8 +: 8];
    end
  end

  // Unexpected lanes count as covered
  assign w_fwd_full = &(w_fwd_mask | ~i_lane_mask);
  assign o_replay   = w_load_ok & i_l1d_rd_miss & ~w_fwd_full;

  // --------------------------------------------------------------------------
  // Size masking and extension
  // --------------------------------------------------------------------------
  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: w_top_bit = w_merged[7];
      lsu_pkg::SIZE_H: w_top_bit = w_merged[15];
      lsu_pkg::SIZE_W: w_top_bit = w_merged[31];
      default:         w_top_bit = w_merged[63];
    endcase
  end

  assign w_fill = (i_sign == lsu_pkg::SIGN_S) & w_top_bit;

  // Lanes outside the access get zero or sign fill
  always_comb begin
    for (int b = 0; b < lsu_pkg::DW_BYTES; b++) begin
      o_load_data[b*8 +: 8] = i_lane_mask[b] ? w_merged[b*8 +: 8] : {8{w_fill}};
    end
  end

endmodule

`default_nettype wire

//--- lsu_patterns.txt
# base offset size sign rd chunk miss fwd_mask fwd_data flush exp_data exp_exc exp_replay
# all hex; size 0..3 is byte, half, word, doubleword
1000 8 0 1 01 f1e2d3c4b5a697887766554433221100 0 00 0 0 ffffffffffffff88 0 0
1000 9 0 0 02 f1e2d3c4b5a697887766554433221100 0 00 0 0 0000000000000097 0 0
1000 a 1 1 03 f1e2d3c4b5a697887766554433221100 0 00 0 0 ffffffffffffb5a6 0 0
1000 2 1 0 04 f1e2d3c4b5a697887766554433221100 0 00 0 0 0000000000003322 0 0
1000 c 2 1 05 f1e2d3c4b5a697887766554433221100 0 00 0 0 fffffffff1e2d3c4 0 0
1000 4 2 0 06 f1e2d3c4b5a697887766554433221100 0 00 0 0 0000000077665544 0 0
1000 8 3 0 07 f1e2d3c4b5a697887766554433221100 0 00 0 0 f1e2d3c4b5a69788 0 0
0ff8 8 3 1 08 f1e2d3c4b5a697887766554433221100 0 00 0 0 7766554433221100 0 0
1000 4 2 1 09 f1e2d3c4b5a697887766554433221100 0 60 00bbaa0000000000 0 0000000077bbaa44 0 0
1000 e 1 0 0a f1e2d3c4b5a697887766554433221100 1 c0 5a3c000000000000 0 0000000000005a3c 0 0
1000 0 3 0 0b f1e2d3c4b5a697887766554433221100 1 0f 00000000deadbeef 0 0 0 1
2000 6 2 0 0c f1e2d3c4b5a697887766554433221100 0 00 0 0 0 1 0
1000 1 0 0 00 f1e2d3c4b5a697887766554433221100 0 00 0 0 0000000000000011 0 0
1000 0 3 0 0d f1e2d3c4b5a697887766554433221100 0 00 0 1 7766554433221100 0 0
1000 8 0 1 0e f1e2d3c4b5a697887766554433221100 0 00 0 1 ffffffffffffff88 0 0
1000 0 1 1 0f f1e2d3c4b5a697887766554433221100 0 00 0 0 0000000000001100 0 0
1000 8 2 0 10 f1e2d3c4b5a697887766554433221100 0 00 0 0 00000000b5a69788 0 0
1000 f 0 1 11 f1e2d3c4b5a697887766554433221100 0 00 0 0 fffffffffffffff1 0 0

//--- lsu_pipe.sv
// Three-stage load pipeline
// EX1 forms the address and reads the L1D chunk, EX2 merges store
// forwarding and extends the data, EX3 reports write-back, a misaligned
// exception or a replay. A flush kills every stage in flight

`default_nettype none

module lsu_pipe #(
  parameter int TAG_W = 6
) (
  input  wire logic                                i_clk,
  input  wire logic                                i_reset_n,

  // EX0 issue
  input  wire logic                                i_ex0_valid,
  input  wire logic [TAG_W-1:0]                    i_ex0_tag,
  input  wire lsu_pkg::xlen_t                      i_ex0_base,
  input  wire lsu_pkg::xlen_t                      i_ex0_offset,
  input  wire lsu_pkg::size_e                      i_ex0_size,
  input  wire logic                                i_ex0_sign,
  input  wire logic [lsu_pkg::RD_IDX_W-1:0]        i_ex0_rd_idx,

  input  wire logic                                i_flush,

  // L1D read, request in EX1 and response in EX2
  output logic                                     o_l1d_rd_valid,
  output lsu_pkg::xlen_t                           o_l1d_rd_addr,
  input  wire logic [lsu_pkg::LINE_BYTES*8-1:0]    i_l1d_rd_data,
  input  wire logic                                i_l1d_rd_miss,

  // Store forwarding, answered in the same cycle
  output logic                                     o_fwd_check_valid,
  output lsu_pkg::xlen_t                           o_fwd_check_addr,
  output lsu_pkg::lane_mask_t                      o_fwd_check_mask,
  input  wire lsu_pkg::lane_mask_t                 i_fwd_mask,
  input  wire lsu_pkg::xlen_t                      i_fwd_data,

  // EX3 completion
  output logic                                     o_ex3_done,
  output logic [TAG_W-1:0]                         o_ex3_tag,
  output logic                                     o_ex3_wr_valid,
  output logic [lsu_pkg::RD_IDX_W-1:0]             o_ex3_rd_idx,
  output lsu_pkg::xlen_t                           o_ex3_wr_data,
  output logic                                     o_ex3_except_valid,
  output lsu_pkg::except_e                         o_ex3_except_type,
  output lsu_pkg::xlen_t                           o_ex3_except_tval,
  output logic                                     o_ex3_replay
);

  // --------------------------------------------------------------------------
  // Stage payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    lsu_pkg::xlen_t               base;
    lsu_pkg::xlen_t               offset;
    lsu_pkg::size_e               size;
    lsu_pkg::sign_t               sign;
    logic [lsu_pkg::RD_IDX_W-1:0] rd_idx;
  } ex1_payload_t;

  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    lsu_pkg::size_e               size;
    lsu_pkg::sign_t               sign;
    logic [lsu_pkg::RD_IDX_W-1:0] rd_idx;
    lsu_pkg::xlen_t               vaddr;
    logic                         misaligned;
    lsu_pkg::lane_mask_t          lane_mask;
  } ex2_payload_t;

  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    logic [lsu_pkg::RD_IDX_W-1:0] rd_idx;
    lsu_pkg::xlen_t               data;
    logic                         except_valid;
    lsu_pkg::xlen_t               addr;
    logic                         replay;
  } ex3_payload_t;

  ex1_payload_t        w_ex1_next;
  ex1_payload_t        r_ex1;
  ex2_payload_t        w_ex2_next;
  ex2_payload_t        r_ex2;
  ex3_payload_t        w_ex3_next;
  ex3_payload_t        r_ex3;
  logic                r_ex1_valid;
  logic                r_ex2_valid;
  logic                r_ex3_valid;

  lsu_pkg::xlen_t      w_ex1_vaddr;
  logic                w_ex1_misaligned;
  lsu_pkg::lane_mask_t w_ex1_lane_mask;
  lsu_pkg::xlen_t      w_ex2_load_data;
  logic                w_ex2_replay;

  // --------------------------------------------------------------------------
  // EX0 to EX1
  // --------------------------------------------------------------------------
  always_comb begin
    w_ex1_next.tag    = i_ex0_tag;
    w_ex1_next.base   = i_ex0_base;
    w_ex1_next.offset = i_ex0_offset;
    w_ex1_next.size   = i_ex0_size;
    w_ex1_next.sign   = lsu_pkg::sign_t'(i_ex0_sign);
    w_ex1_next.rd_idx = i_ex0_rd_idx;
  end

  lsu_stage_reg #(.T_PAYLOAD(ex1_payload_t)) u_ex1_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_ex0_valid),
    .i_kill    (i_flush),
    .i_payload (w_ex1_next),
    .o_valid   (r_ex1_valid),
    .o_payload (r_ex1)
  );

  // --------------------------------------------------------------------------
  // EX1
  // --------------------------------------------------------------------------
  lsu_agen u_agen (
    .i_valid        (r_ex1_valid),
    .i_base         (r_ex1.base),
    .i_offset       (r_ex1.offset),
    .i_size         (r_ex1.size),
    .o_vaddr        (w_ex1_vaddr),
    .o_misaligned   (w_ex1_misaligned),
    .o_lane_mask    (w_ex1_lane_mask),
    .o_l1d_rd_valid (o_l1d_rd_valid),
    .o_l1d_rd_addr  (o_l1d_rd_addr)
  );

  always_comb begin
    w_ex2_next.tag        = r_ex1.tag;
    w_ex2_next.size       = r_ex1.size;
    w_ex2_next.sign       = r_ex1.sign;
    w_ex2_next.rd_idx     = r_ex1.rd_idx;
    w_ex2_next.vaddr      = w_ex1_vaddr;
    w_ex2_next.misaligned = w_ex1_misaligned;
    w_ex2_next.lane_mask  = w_ex1_lane_mask;
  end

  lsu_stage_reg #(.T_PAYLOAD(ex2_payload_t)) u_ex2_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (r_ex1_valid),
    .i_kill    (i_flush),
    .i_payload (w_ex2_next),
    .o_valid   (r_ex2_valid),
    .o_payload (r_ex2)
  );

  // --------------------------------------------------------------------------
  // EX2
  // --------------------------------------------------------------------------
  // Forward check covers the whole doubleword holding the load
  assign o_fwd_check_addr = {r_ex2.vaddr[lsu_pkg::XLEN-1:lsu_pkg::DW_OFS_W],
                             {lsu_pkg::DW_OFS_W{1'b0}}};

  lsu_load_align u_load_align (
    .i_valid           (r_ex2_valid),
    .i_misaligned      (r_ex2.misaligned),
    .i_vaddr           (r_ex2.vaddr),
    .i_size            (r_ex2.size),
    .i_sign            (r_ex2.sign),
    .i_lane_mask       (r_ex2.lane_mask),
    .i_l1d_rd_data     (i_l1d_rd_data),
    .i_l1d_rd_miss     (i_l1d_rd_miss),
    .i_fwd_mask        (i_fwd_mask),
    .i_fwd_data        (i_fwd_data),
    .o_fwd_check_valid (o_fwd_check_valid),
    .o_fwd_check_mask  (o_fwd_check_mask),
    .o_load_data       (w_ex2_load_data),
    .o_replay          (w_ex2_replay)
  );

  always_comb begin
    w_ex3_next.tag          = r_ex2.tag;
    w_ex3_next.rd_idx       = r_ex2.rd_idx;
    w_ex3_next.data         = w_ex2_load_data;
    w_ex3_next.except_valid = r_ex2.misaligned;
    w_ex3_next.addr         = r_ex2.vaddr;
    w_ex3_next.replay       = w_ex2_replay;
  end

  lsu_stage_reg #(.T_PAYLOAD(ex3_payload_t)) u_ex3_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (r_ex2_valid),
    .i_kill    (i_flush),
    .i_payload (w_ex3_next),
    .o_valid   (r_ex3_valid),
    .o_payload (r_ex3)
  );

  // --------------------------------------------------------------------------
  // EX3 completion
  // --------------------------------------------------------------------------
  assign o_ex3_done         = r_ex3_valid;
  assign o_ex3_tag          = r_ex3.tag;
  assign o_ex3_rd_idx       = r_ex3.rd_idx;
  assign o_ex3_wr_data      = r_ex3.data;
  assign o_ex3_except_valid = r_ex3_valid & r_ex3.except_valid;
  assign o_ex3_except_type  = r_ex3.except_valid ? lsu_pkg::EXC_LOAD_ADDR_MISALIGN
                                                 : lsu_pkg::EXC_NONE;
  assign o_ex3_except_tval  = r_ex3.addr;
  assign o_ex3_replay       = r_ex3_valid & r_ex3.replay;

  // x0 is never written
  assign o_ex3_wr_valid = r_ex3_valid & ~r_ex3.except_valid & ~r_ex3.replay &
                          (r_ex3.rd_idx != '0);

endmodule

`default_nettype wire

//--- lsu_pipe_checker.sv
// Load pipeline protocol checker
// Concurrent assertions on the EX3 result flags and the fixed
// latency from the L1D request to completion

`default_nettype none

module lsu_pipe_checker (
  input wire logic i_clk,
  input wire logic i_reset_n,
  input wire logic i_flush,
  input wire logic o_l1d_rd_valid,
  input wire logic o_ex3_done,
  input wire logic o_ex3_wr_valid,
  input wire logic o_ex3_except_valid,
  input wire logic o_ex3_replay
);

  a_wr_needs_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ex3_wr_valid |-> o_ex3_done)
    else $error("write-back without done");

  a_wr_not_except: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_ex3_wr_valid && o_ex3_except_valid))
    else $error("write-back together with an exception");

  a_replay_not_except: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_ex3_replay && o_ex3_except_valid))
    else $error("replay together with an exception");

  // Request in EX1 completes in EX3 unless a flush hits EX1 or EX2
  a_req_completes: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_l1d_rd_valid && !i_flush) ##1 !i_flush |=> o_ex3_done)
    else $error("cache request without completion two cycles later");

endmodule

bind lsu_pipe lsu_pipe_checker u_checker (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_flush            (i_flush),
  .o_l1d_rd_valid     (o_l1d_rd_valid),
  .o_ex3_done         (o_ex3_done),
  .o_ex3_wr_valid     (o_ex3_wr_valid),
  .o_ex3_except_valid (o_ex3_except_valid),
  .o_ex3_replay       (o_ex3_replay)
);

`default_nettype wire

//--- lsu_pkg.sv
// Load pipeline shared definitions
// Data and address widths, cache chunk geometry, access size,
// sign flag and exception codes used across the EX1 to EX3 stages

`default_nettype none

package lsu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int XLEN       = 64;
  localparam int DW_BYTES   = 8;
  localparam int DW_OFS_W   = $clog2(DW_BYTES);
  localparam int LINE_BYTES = 16;
  localparam int LINE_OFS_W = $clog2(LINE_BYTES);
  localparam int RD_IDX_W   = 5;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [DW_BYTES-1:0] lane_mask_t;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  // Access size in bytes is 1 << size
  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,
    SIZE_H  = 2'b01,
    SIZE_W  = 2'b10,
    SIZE_DW = 2'b11
  } size_e;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_t;

  // RISC-V mcause numbering
  typedef enum logic [3:0] {
    EXC_NONE               = 4'd0,
    EXC_LOAD_ADDR_MISALIGN = 4'd4
  } except_e;

endpackage

`default_nettype wire

//--- lsu_stage_reg.sv
// Generic pipeline stage register
// Holds one valid bit and a payload of any packed type.
// A kill drops the valid bit at the clock edge

`default_nettype none

module lsu_stage_reg #(
  parameter type T_PAYLOAD = logic
) (
  input  wire logic     i_clk,
  input  wire logic     i_reset_n,

  input  wire logic     i_valid,
  input  wire logic     i_kill,
  input  wire T_PAYLOAD i_payload,

  output logic          o_valid,
  output T_PAYLOAD      o_payload
);

  // Valid bit, cleared on kill
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & ~i_kill;
    end
  end

  // Payload only captured for a live entry
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_payload <= i_payload;
    end
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a few cycles

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2 o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_lsu_pipe.sv
// Load pipeline testbench
// Reads load rows from the pattern file, issues them with random gaps,
// answers the L1D and forwarding ports from the row in EX2 and checks
// every EX3 result in issue order

`default_nettype none

module tb_lsu_pipe;

  localparam int MAX_ROWS     = 32;
  localparam int DRAIN_CYCLES = 100;

  logic         i_clk;
  logic         i_reset_n;
  logic         i_ex0_valid;
  logic [5:0]   i_ex0_tag;
  logic [63:0]  i_ex0_base;
  logic [63:0]  i_ex0_offset;
  logic [1:0]   i_ex0_size;
  logic         i_ex0_sign;
  logic [4:0]   i_ex0_rd_idx;
  logic         i_flush;
  logic [127:0] i_l1d_rd_data;
  logic         i_l1d_rd_miss;
  logic [7:0]   i_fwd_mask;
  logic [63:0]  i_fwd_data;
  logic         o_l1d_rd_valid;
  logic [63:0]  o_l1d_rd_addr;
  logic         o_fwd_check_valid;
  logic [63:0]  o_fwd_check_addr;
  logic [7:0]   o_fwd_check_mask;
  logic         o_ex3_done;
  logic [5:0]   o_ex3_tag;
  logic         o_ex3_wr_valid;
  logic [4:0]   o_ex3_rd_idx;
  logic [63:0]  o_ex3_wr_data;
  logic         o_ex3_except_valid;
  lsu_pkg::except_e o_ex3_except_type;
  logic [63:0]  o_ex3_except_tval;
  logic         o_ex3_replay;

  // Pattern rows
  logic [63:0]  base_a[MAX_ROWS];
  logic [63:0]  ofs_a[MAX_ROWS];
  logic [3:0]   size_a[MAX_ROWS];
  logic [3:0]   sign_a[MAX_ROWS];
  logic [7:0]   rd_a[MAX_ROWS];
  logic [127:0] chunk_a[MAX_ROWS];
  logic [3:0]   miss_a[MAX_ROWS];
  logic [7:0]   fmask_a[MAX_ROWS];
  logic [63:0]  fdata_a[MAX_ROWS];
  logic [3:0]   flush_a[MAX_ROWS];
  logic [63:0]  exp_data_a[MAX_ROWS];
  logic [3:0]   exp_exc_a[MAX_ROWS];
  logic [3:0]   exp_replay_a[MAX_ROWS];
  bit           bad_a[MAX_ROWS];

  int n_rows;
  int err_count;
  int n_done;
  int cur_test;
  int seed = 83811;
  int issue_row = -1;
  int ex1_row = -1;
  int ex2_row = -1;
  int ex3_row = -1;
  int exp_q[$];

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clock_gen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  lsu_pipe #(.TAG_W(6)) i_dut (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_ex0_valid(i_ex0_valid), .i_ex0_tag(i_ex0_tag), .i_ex0_base(i_ex0_base),
    .i_ex0_offset(i_ex0_offset), .i_ex0_size(lsu_pkg::size_e'(i_ex0_size)),
    .i_ex0_sign(i_ex0_sign), .i_ex0_rd_idx(i_ex0_rd_idx), .i_flush(i_flush),
    .o_l1d_rd_valid(o_l1d_rd_valid), .o_l1d_rd_addr(o_l1d_rd_addr),
    .i_l1d_rd_data(i_l1d_rd_data), .i_l1d_rd_miss(i_l1d_rd_miss),
    .o_fwd_check_valid(o_fwd_check_valid), .o_fwd_check_addr(o_fwd_check_addr),
    .o_fwd_check_mask(o_fwd_check_mask), .i_fwd_mask(i_fwd_mask), .i_fwd_data(i_fwd_data),
    .o_ex3_done(o_ex3_done), .o_ex3_tag(o_ex3_tag), .o_ex3_wr_valid(o_ex3_wr_valid),
    .o_ex3_rd_idx(o_ex3_rd_idx), .o_ex3_wr_data(o_ex3_wr_data),
    .o_ex3_except_valid(o_ex3_except_valid), .o_ex3_except_type(o_ex3_except_type),
    .o_ex3_except_tval(o_ex3_except_tval), .o_ex3_replay(o_ex3_replay)
  );

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
      err_count++;
      bad_a[cur_test] = 1'b1;
    end
  endtask

  // One lane per byte of the access, size is log2 of the byte count
  function automatic logic [7:0] lanes_for_size(input logic [1:0] size);
    logic [8:0] lanes;
    lanes = (9'd1 << (4'd1 << size)) - 9'd1;
    return lanes[7:0];
  endfunction

  task automatic read_patterns();
    int fd;
    int cnt;
    string line;
    n_rows = 0;
    fd = $fopen("lsu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      err_count++;
    end else begin
      while (!$feof(fd) && n_rows < MAX_ROWS) begin
        cnt = $fgets(line, fd);
        if (cnt > 4 && line[0] != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        base_a[n_rows], ofs_a[n_rows], size_a[n_rows], sign_a[n_rows],
                        rd_a[n_rows], chunk_a[n_rows], miss_a[n_rows], fmask_a[n_rows],
                        fdata_a[n_rows], flush_a[n_rows], exp_data_a[n_rows],
                        exp_exc_a[n_rows], exp_replay_a[n_rows]);
          if (cnt == 13) n_rows++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_idle();
    i_ex0_valid = 1'b0;
    issue_row   = -1;
  endtask

  task automatic drive_load(input int r);
    i_ex0_valid  = 1'b1;
    i_ex0_tag    = r[5:0];
    i_ex0_base   = base_a[r];
    i_ex0_offset = ofs_a[r];
    i_ex0_size   = size_a[r][1:0];
    i_ex0_sign   = sign_a[r][0];
    i_ex0_rd_idx = rd_a[r][4:0];
    issue_row    = r;
  endtask

  // Shadow of which row sits in EX1, EX2 and EX3
  always @(posedge i_clk) begin
    ex3_row <= i_flush ? -1 : ex2_row;
    ex2_row <= i_flush ? -1 : ex1_row;
    ex1_row <= (i_flush || !i_ex0_valid) ? -1 : issue_row;
  end

  // Cache and forwarding answers for the load in EX2
  always @(posedge i_clk) begin
    #2;
    if (ex2_row >= 0) begin
      i_l1d_rd_data = chunk_a[ex2_row];
      i_l1d_rd_miss = miss_a[ex2_row][0];
      i_fwd_mask    = fmask_a[ex2_row];
      i_fwd_data    = fdata_a[ex2_row];
    end else begin
      i_l1d_rd_data = '0;
      i_l1d_rd_miss = 1'b0;
      i_fwd_mask    = '0;
      i_fwd_data    = '0;
    end
  end

  // ---------------------------------------------------------------------------
  // Result monitor
  // ---------------------------------------------------------------------------
  always @(posedge i_clk) begin
    logic [63:0] addr;
    logic [7:0]  exp_mask;
    logic        exp_wr;
    int          r;
    if (i_reset_n) begin
      if (ex1_row >= 0) begin
        cur_test = ex1_row;
        addr = base_a[ex1_row] + ofs_a[ex1_row];
        compare_field("o_l1d_rd_valid", 64'(o_l1d_rd_valid), 64'(!exp_exc_a[ex1_row][0]));
        if (!exp_exc_a[ex1_row][0])
          compare_field("o_l1d_rd_addr", o_l1d_rd_addr, {addr[63:4], 4'h0});
      end else if (o_l1d_rd_valid) begin
        $display("Cache request raised with no load in EX1");
        err_count++;
      end

      // Forward check of the doubleword in EX2
      if (ex2_row >= 0) begin
        cur_test = ex2_row;
        addr = base_a[ex2_row] + ofs_a[ex2_row];
        exp_mask = lanes_for_size(size_a[ex2_row][1:0]) << addr[2:0];
        compare_field("o_fwd_check_valid", 64'(o_fwd_check_valid),
                      64'(!exp_exc_a[ex2_row][0]));
        if (!exp_exc_a[ex2_row][0]) begin
          compare_field("o_fwd_check_addr", o_fwd_check_addr, {addr[63:3], 3'h0});
          compare_field("o_fwd_check_mask", 64'(o_fwd_check_mask), 64'(exp_mask));
        end
      end else if (o_fwd_check_valid) begin
        $display("Forward check raised with no load in EX2");
        err_count++;
      end

      if (o_ex3_done) begin
        if (exp_q.size() == 0) begin
          $display("Load result seen with no load outstanding");
          err_count++;
        end else begin
          r = exp_q.pop_front();
          cur_test = r;
          addr = base_a[r] + ofs_a[r];
          exp_wr = !exp_exc_a[r][0] && !exp_replay_a[r][0] && rd_a[r] != 8'h0;
          if (r != ex3_row) begin
            $display("test %0d: result not three cycles after issue", r);
            err_count++;
            bad_a[r] = 1'b1;
          end
          compare_field("o_ex3_tag", 64'(o_ex3_tag), 64'(r[5:0]));
          compare_field("o_ex3_except_valid", 64'(o_ex3_except_valid), 64'(exp_exc_a[r]));
          compare_field("o_ex3_replay", 64'(o_ex3_replay), 64'(exp_replay_a[r]));
          compare_field("o_ex3_wr_valid", 64'(o_ex3_wr_valid), 64'(exp_wr));
          compare_field("o_ex3_rd_idx", 64'(o_ex3_rd_idx), 64'(rd_a[r]));
          compare_field("o_ex3_except_type", 64'(o_ex3_except_type),
                        exp_exc_a[r][0] ? 64'h4 : 64'h0);
          if (exp_exc_a[r][0]) begin
            compare_field("o_ex3_except_tval", o_ex3_except_tval, addr);
          end else if (!exp_replay_a[r][0]) begin
            compare_field("o_ex3_wr_data", o_ex3_wr_data, exp_data_a[r]);
          end
          n_done++;
          $display("test %0d at %h: %s", r, addr, bad_a[r] ? "failed" : "passed");
        end
      end else if (ex3_row >= 0) begin
        $display("test %0d: no result three cycles after issue", ex3_row);
        err_count++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  initial begin
    int gap;
    int wait_cnt;
    int k;
    i_ex0_valid = 1'b0;
    i_ex0_tag = '0;
    i_ex0_base = '0;
    i_ex0_offset = '0;
    i_ex0_size = '0;
    i_ex0_sign = 1'b0;
    i_ex0_rd_idx = '0;
    i_flush = 1'b0;
    i_l1d_rd_data = '0;
    i_l1d_rd_miss = 1'b0;
    i_fwd_mask = '0;
    i_fwd_data = '0;
    err_count = 0;
    n_done = 0;
    read_patterns();

    wait_cnt = 0;
    while (!i_reset_n && wait_cnt < 20) begin
      @(posedge i_clk);
      wait_cnt++;
    end
    if (!i_reset_n) begin
      $display("Timeout waiting for reset release");
      err_count++;
    end else begin
      for (int r = 0; r < n_rows; r++) begin
        // Later rows go back to back
        gap = (r < 13) ? (($random(seed) & 32'h7fff_ffff) % 3) : 0;
        repeat (gap) begin
          @(posedge i_clk);
          #2 drive_idle();
        end
        @(posedge i_clk);
        #2 drive_load(r);
        if (!flush_a[r][0]) begin
          exp_q.push_back(r);
        end else if (r == n_rows - 1 || !flush_a[r + 1][0]) begin
          // Flush while the group is in flight
          @(posedge i_clk);
          #2 drive_idle();
          i_flush = 1'b1;
          k = r;
          while (k >= 0 && flush_a[k][0]) begin
            $display("test %0d: killed by flush", k);
            k--;
          end
          @(posedge i_clk);
          #2 i_flush = 1'b0;
        end
      end
      @(posedge i_clk);
      #2 drive_idle();

      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < DRAIN_CYCLES) begin
        @(posedge i_clk);
        wait_cnt++;
      end
      if (exp_q.size() != 0) begin
        $display("Timeout waiting for %0d load results", exp_q.size());
        err_count++;
      end
      repeat (4) @(posedge i_clk);
    end

    $display("%0d rows, %0d results checked, %0d errors", n_rows, n_done, err_count);
    if (err_count == 0 && n_rows > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
lsu_pkg.sv
lsu_stage_reg.sv
lsu_agen.sv
lsu_load_align.sv
lsu_pipe.sv
tb_clock_gen.sv
lsu_pipe_checker.sv
tb_lsu_pipe.sv
